// File: epu_assert.sv
`default_nettype none

module epu_assert (
    input wire logic              clk,
    input wire logic              rst,
    input wire epu_pkg::wb_req_t  wb_req_i,
    input wire epu_pkg::wb_rsp_t  wb_rsp_i,
    input wire logic              done_i,
    input wire logic              busy_i,
    input wire epu_pkg::epu_cfg_t cfg_i,
    input wire epu_pkg::buf_req_t in_eng_req_i,
    input wire epu_pkg::buf_req_t out_eng_req_i
);

    // Ack lasts one cycle
    ack_single: assert property (@(posedge clk) disable iff (!rst)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else $error("Wishbone ack held high for two cycles");

    ack_after_stb: assert property (@(posedge clk) disable iff (!rst)
        wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else $error("Wishbone ack without a preceding cyc and stb");

    done_while_busy: assert property (@(posedge clk) disable iff (!rst)
        done_i |-> $past(busy_i))
        else $error("done pulse while the engine was idle");

    // Engine results stay inside the output length
    in_write_range: assert property (@(posedge clk) disable iff (!rst)
        (in_eng_req_i.en && in_eng_req_i.we) |-> (in_eng_req_i.addr < cfg_i.out_len))
        else $error("engine wrote the input buffer beyond out_len");

    out_write_range: assert property (@(posedge clk) disable iff (!rst)
        (out_eng_req_i.en && out_eng_req_i.we) |-> (out_eng_req_i.addr < cfg_i.out_len))
        else $error("engine wrote the output buffer beyond out_len");

endmodule

bind epu_top epu_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .wb_req_i      (wb_i),
    .wb_rsp_i      (wb_o),
    .done_i        (done_o),
    .busy_i        (busy),
    .cfg_i         (cfg),
    .in_eng_req_i  (in_eng_req),
    .out_eng_req_i (out_eng_req)
);

`default_nettype wire

// File: epu_buffer.sv
`default_nettype none

module epu_buffer #(
    parameter int BUF_DEPTH = 64
) (
    input  wire logic              clk,
    input  wire epu_pkg::buf_req_t bus_req_i,
    output logic [31:0]            bus_rdata_o,
    input  wire epu_pkg::buf_req_t eng_req_i,
    output logic [31:0]            eng_rdata_o
);

    localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

    logic [31:0]   mem [BUF_DEPTH];
    logic [AW-1:0] bus_addr;
    logic [AW-1:0] eng_addr;

    assign bus_addr = bus_req_i.addr[AW-1:0];
    assign eng_addr = eng_req_i.addr[AW-1:0];

    // Engine write comes last so it wins on an address clash
    always_ff @(posedge clk) begin
        if (bus_req_i.en && bus_req_i.we)
            mem[bus_addr] <= bus_req_i.wdata;
        if (eng_req_i.en && eng_req_i.we)
            mem[eng_addr] <= eng_req_i.wdata;
    end

    // Registered read on each port
    always_ff @(posedge clk) begin
        if (bus_req_i.en && !bus_req_i.we)
            bus_rdata_o <= mem[bus_addr];
    end

    always_ff @(posedge clk) begin
        if (eng_req_i.en && !eng_req_i.we)
            eng_rdata_o <= mem[eng_addr];
    end

endmodule

`default_nettype wire

// File: epu_bus_slave.sv
`default_nettype none

module epu_bus_slave (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire epu_pkg::wb_req_t   wb_i,
    output epu_pkg::wb_rsp_t        wb_o,
    output epu_pkg::buf_req_t       in_req_o,
    output epu_pkg::buf_req_t       wt_req_o,
    output epu_pkg::buf_req_t       out_req_o,
    input  wire logic [31:0]        in_rdata_i,
    input  wire logic [31:0]        wt_rdata_i,
    input  wire logic [31:0]        out_rdata_i,
    output epu_pkg::epu_cfg_t       cfg_o,
    output logic                    start_o,
    input  wire logic               busy_i,
    input  wire logic               done_i
);

    logic                       sample;
    logic                       csr_wr;
    logic                       ack_q;
    logic                       start_q;
    logic                       done_sticky_q;
    epu_pkg::region_e           region;
    epu_pkg::region_e           region_q;
    epu_pkg::csr_e              csr_idx;
    epu_pkg::buf_req_t          buf_req;
    epu_pkg::epu_mode_e         mode_q;
    logic                       swap_q;
    logic [31:0]                bias_q;
    logic [epu_pkg::BUF_AW-1:0] out_len_q;
    logic [epu_pkg::BUF_AW-1:0] ker_len_q;
    logic [31:0]                csr_rdata;
    logic [31:0]                csr_rdata_q;

    // A new transfer is taken only while ack is low
    assign sample  = wb_i.cyc && wb_i.stb && !ack_q;
    assign region  = epu_pkg::region_e'(wb_i.adr[epu_pkg::ADDR_W-1 -: 2]);
    assign csr_idx = epu_pkg::csr_e'(wb_i.adr[2:0]);
    assign csr_wr  = sample && wb_i.we && (region == epu_pkg::REGION_CSR);

    always_comb begin
        buf_req.en    = sample;
        buf_req.we    = wb_i.we;
        buf_req.addr  = wb_i.adr[epu_pkg::BUF_AW-1:0];
        buf_req.wdata = wb_i.dat;
        in_req_o      = buf_req;
        wt_req_o      = buf_req;
        out_req_o     = buf_req;
        in_req_o.en   = sample && (region == epu_pkg::REGION_INPUT);
        wt_req_o.en   = sample && (region == epu_pkg::REGION_WEIGHT);
        out_req_o.en  = sample && (region == epu_pkg::REGION_OUTPUT);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode_q        <= epu_pkg::MODE_CONV;
            swap_q        <= 1'b0;
            bias_q        <= '0;
            out_len_q     <= '0;
            ker_len_q     <= '0;
            start_q       <= 1'b0;
            done_sticky_q <= 1'b0;
        end else begin
            start_q <= csr_wr && (csr_idx == epu_pkg::CSR_CTRL) && wb_i.dat[0] && !busy_i;
            if (csr_wr) begin
                case (csr_idx)
                    epu_pkg::CSR_CTRL: begin
                        mode_q <= epu_pkg::epu_mode_e'(wb_i.dat[1]);
                        swap_q <= wb_i.dat[2];
                    end
                    epu_pkg::CSR_BIAS:    bias_q    <= wb_i.dat;
                    epu_pkg::CSR_OUT_LEN: out_len_q <= wb_i.dat[epu_pkg::BUF_AW-1:0];
                    epu_pkg::CSR_KER_LEN: ker_len_q <= wb_i.dat[epu_pkg::BUF_AW-1:0];
                    default: ;
                endcase
            end
            // Sticky done, cleared by the next start
            if (start_q)
                done_sticky_q <= 1'b0;
            else if (done_i)
                done_sticky_q <= 1'b1;
        end
    end

    always_comb begin
        case (csr_idx)
            epu_pkg::CSR_CTRL:    csr_rdata = {29'b0, swap_q, mode_q, 1'b0};
            epu_pkg::CSR_STATUS:  csr_rdata = {30'b0, done_sticky_q, busy_i};
            epu_pkg::CSR_BIAS:    csr_rdata = bias_q;
            epu_pkg::CSR_OUT_LEN: csr_rdata = {{(32-epu_pkg::BUF_AW){1'b0}}, out_len_q};
            epu_pkg::CSR_KER_LEN: csr_rdata = {{(32-epu_pkg::BUF_AW){1'b0}}, ker_len_q};
            default:              csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack_q       <= 1'b0;
            region_q    <= epu_pkg::REGION_INPUT;
            csr_rdata_q <= '0;
        end else begin
            ack_q <= sample;
            if (sample) begin
                region_q    <= region;
                csr_rdata_q <= csr_rdata;
            end
        end
    end

    // Buffer data is already registered, so it lines up with ack
    always_comb begin
        wb_o.ack = ack_q;
        case (region_q)
            epu_pkg::REGION_INPUT:  wb_o.dat = in_rdata_i;
            epu_pkg::REGION_WEIGHT: wb_o.dat = wt_rdata_i;
            epu_pkg::REGION_OUTPUT: wb_o.dat = out_rdata_i;
            default:                wb_o.dat = csr_rdata_q;
        endcase
    end

    assign start_o = start_q;
    assign cfg_o   = '{mode: mode_q, swap: swap_q, bias: bias_q,
                       out_len: out_len_q, ker_len: ker_len_q};

endmodule

`default_nettype wire

// File: epu_conv_engine.sv
`default_nettype none

module epu_conv_engine #(
    parameter int BUF_DEPTH = 64
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start_i,
    input  wire epu_pkg::epu_cfg_t cfg_i,
    output logic                   busy_o,
    output logic                   done_o,
    output epu_pkg::buf_req_t      in_req_o,
    output epu_pkg::buf_req_t      wt_req_o,
    output epu_pkg::buf_req_t      out_req_o,
    input  wire logic [31:0]       in_rdata_i,
    input  wire logic [31:0]       wt_rdata_i,
    input  wire logic [31:0]       out_rdata_i
);

    epu_pkg::engine_state_e     state_q;
    epu_pkg::epu_cfg_t          cfg_q;
    logic [epu_pkg::BUF_AW-1:0] out_idx_q;
    logic [epu_pkg::BUF_AW-1:0] ker_idx_q;
    logic [31:0]                acc_q;
    logic                       mac_vld_q;
    logic                       done_q;
    logic                       last_ker;
    logic                       last_out;
    logic [31:0]                src_rdata;
    logic [31:0]                result;
    epu_pkg::buf_req_t          rd_req;
    epu_pkg::buf_req_t          wr_req;

    assign last_ker = (ker_idx_q == cfg_q.ker_len - 1'b1);
    // Never run past the end of the buffer
    assign last_out = (out_idx_q == cfg_q.out_len - 1'b1) ||
                      (int'(out_idx_q) == BUF_DEPTH - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q   <= epu_pkg::ENG_IDLE;
            cfg_q     <= '0;
            out_idx_q <= '0;
            ker_idx_q <= '0;
            mac_vld_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q    <= 1'b0;
            mac_vld_q <= 1'b0;
            case (state_q)
                epu_pkg::ENG_IDLE: begin
                    if (start_i) begin
                        cfg_q     <= cfg_i;
                        out_idx_q <= '0;
                        state_q   <= epu_pkg::ENG_INIT;
                    end
                end
                epu_pkg::ENG_INIT: begin
                    ker_idx_q <= '0;
                    state_q   <= epu_pkg::ENG_MAC;
                end
                epu_pkg::ENG_MAC: begin
                    // Data for this read arrives next cycle
                    mac_vld_q <= 1'b1;
                    if (last_ker)
                        state_q <= epu_pkg::ENG_DRAIN;
                    else
                        ker_idx_q <= ker_idx_q + 1'b1;
                end
                epu_pkg::ENG_DRAIN: state_q <= epu_pkg::ENG_WRITE;
                epu_pkg::ENG_WRITE: begin
                    if (last_out) begin
                        done_q  <= 1'b1;
                        state_q <= epu_pkg::ENG_IDLE;
                    end else begin
                        out_idx_q <= out_idx_q + 1'b1;
                        state_q   <= epu_pkg::ENG_INIT;
                    end
                end
                default: state_q <= epu_pkg::ENG_IDLE;
            endcase
        end
    end

    assign src_rdata = cfg_q.swap ? out_rdata_i : in_rdata_i;

    // Low 32 bits of each product, wrapping sum
    always_ff @(posedge clk) begin
        if (state_q == epu_pkg::ENG_INIT)
            acc_q <= cfg_q.bias;
        else if (mac_vld_q)
            acc_q <= acc_q + src_rdata * wt_rdata_i;
    end

    assign result = (cfg_q.mode == epu_pkg::MODE_CONV_RELU && acc_q[31]) ? '0 : acc_q;

    always_comb begin
        rd_req       = '{en: (state_q == epu_pkg::ENG_MAC), we: 1'b0,
                         addr: out_idx_q + ker_idx_q, wdata: '0};
        wr_req       = '{en: (state_q == epu_pkg::ENG_WRITE), we: 1'b1,
                         addr: out_idx_q, wdata: result};
        wt_req_o     = rd_req;
        wt_req_o.addr = ker_idx_q;
        // Swap turns the output buffer into the source
        in_req_o     = cfg_q.swap ? wr_req : rd_req;
        out_req_o    = cfg_q.swap ? rd_req : wr_req;
    end

    assign busy_o = (state_q != epu_pkg::ENG_IDLE);
    assign done_o = done_q;

endmodule

`default_nettype wire

// File: epu_pkg.sv
`default_nettype none

package epu_pkg;

    // Wishbone word address and buffer address widths
    localparam int ADDR_W = 12;
    localparam int BUF_AW = 8;

    // Region select from address bits 11:10
    typedef enum logic [1:0] {
        REGION_INPUT  = 2'd0,
        REGION_WEIGHT = 2'd1,
        REGION_OUTPUT = 2'd2,
        REGION_CSR    = 2'd3
    } region_e;

    // Register offsets within the CSR window
    typedef enum logic [2:0] {
        CSR_CTRL    = 3'd0,
        CSR_STATUS  = 3'd1,
        CSR_BIAS    = 3'd2,
        CSR_OUT_LEN = 3'd3,
        CSR_KER_LEN = 3'd4
    } csr_e;

    typedef enum logic {
        MODE_CONV      = 1'b0,
        MODE_CONV_RELU = 1'b1
    } epu_mode_e;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_INIT,
        ENG_MAC,
        ENG_DRAIN,
        ENG_WRITE
    } engine_state_e;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [31:0]       dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic              en;
        logic              we;
        logic [BUF_AW-1:0] addr;
        logic [31:0]       wdata;
    } buf_req_t;

    typedef struct packed {
        epu_mode_e         mode;
        logic              swap;
        logic [31:0]       bias;
        logic [BUF_AW-1:0] out_len;
        logic [BUF_AW-1:0] ker_len;
    } epu_cfg_t;

endpackage

`default_nettype wire

// File: epu_tb.sv
`default_nettype none

module epu_tb;

    localparam int DEPTH        = 64;
    localparam int MAX_SPAN     = 48;
    localparam int ACK_TIMEOUT  = 16;
    localparam int DONE_TIMEOUT = 5000;

    logic             clk;
    logic             rst;
    epu_pkg::wb_req_t wb_req;
    epu_pkg::wb_rsp_t wb_rsp;
    logic             done;

    logic [31:0] rng_state;
    int          value_errs;
    int          other_errs;
    int          done_pulses = 0;

    // Model copies of the three buffers
    logic [31:0] in_m  [DEPTH];
    logic [31:0] wt_m  [DEPTH];
    logic [31:0] out_m [DEPTH];

    tb_clock_gen #(.PERIOD(8)) u_clk (.clk_o(clk));

    epu_top DUT (
        .clk    (clk),
        .rst    (rst),
        .wb_i   (wb_req),
        .wb_o   (wb_rsp),
        .done_o (done)
    );

    // Count done pulses away from the active edge
    always @(negedge clk) begin
        if (done)
            done_pulses = done_pulses + 1;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_rand();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    function int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'({8'd0, r[31:8]}) % n;
    endfunction

    function automatic logic [11:0] buf_addr(input epu_pkg::region_e r, input int idx);
        logic [7:0] a;
        a = 8'(idx);
        return {r, 2'b00, a};
    endfunction

    function automatic logic [11:0] csr_addr(input epu_pkg::csr_e c);
        return {epu_pkg::REGION_CSR, 7'd0, c};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            value_errs++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, want);
        end
    endtask

    task automatic check_status(input logic [31:0] got, input logic want_busy,
                                input logic want_done);
        logic [31:0] want;
        want = {30'd0, want_done, want_busy};
        if (got !== want) begin
            value_errs++;
            $display("ERR t=%0t csr_status got %h exp %h", $time, got, want);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int want);
        if (got != want) begin
            value_errs++;
            $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, want);
        end
    endtask

    // One classic cycle, counted from the cycle stb goes high
    task automatic wb_access(input logic we, input logic [11:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        bit acked;
        n = 1;
        acked = 1'b0;
        rdata = 'x;
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdata;
        while (!acked && n <= ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdata = wb_rsp.dat;
            end
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        if (acked) begin
            check_cycles("ack latency", n, 2);
        end else begin
            other_errs++;
            $display("Timeout: no Wishbone ack for address %h", adr);
        end
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic write_csr(input epu_pkg::csr_e c, input logic [31:0] data);
        wb_write(csr_addr(c), data);
    endtask

    task automatic read_csr(input epu_pkg::csr_e c, output logic [31:0] data);
        wb_read(csr_addr(c), data);
    endtask

    task automatic configure(input logic [31:0] bias, input int n, input int k);
        write_csr(epu_pkg::CSR_BIAS, bias);
        write_csr(epu_pkg::CSR_OUT_LEN, 32'(n));
        write_csr(epu_pkg::CSR_KER_LEN, 32'(k));
    endtask

    task automatic start_run(input epu_pkg::epu_mode_e mode, input logic swap);
        write_csr(epu_pkg::CSR_CTRL, {29'd0, swap, mode, 1'b1});
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_done(output int cycles);
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (done)
                seen = 1'b1;
        end
        if (!seen) begin
            other_errs++;
            $display("Timeout: the engine never raised done");
        end
    endtask

    // Reference convolution, 32-bit wrap, swap picks source and destination
    task automatic model_conv(input epu_pkg::epu_mode_e mode, input logic swap,
                              input logic [31:0] bias, input int n, input int k);
        logic [31:0] acc;
        for (int i = 0; i < n; i++) begin
            acc = bias;
            for (int j = 0; j < k; j++) begin
                if (swap)
                    acc = acc + out_m[i + j] * wt_m[j];
                else
                    acc = acc + in_m[i + j] * wt_m[j];
            end
            if (mode == epu_pkg::MODE_CONV_RELU && acc[31])
                acc = 32'd0;
            if (swap)
                in_m[i] = acc;
            else
                out_m[i] = acc;
        end
    endtask

    task automatic verify_buffer(input epu_pkg::region_e r, input logic [31:0] want [DEPTH],
                                 input string name);
        logic [31:0] got;
        for (int i = 0; i < DEPTH; i++) begin
            wb_read(buf_addr(r, i), got);
            check_word($sformatf("%s[%0d]", name, i), got, want[i]);
        end
    endtask

    task automatic do_run(input epu_pkg::epu_mode_e mode, input logic swap,
                          input logic [31:0] bias, input int n, input int k);
        int cycles;
        int pulses_before;
        configure(bias, n, k);
        model_conv(mode, swap, bias, n, k);
        pulses_before = done_pulses;
        start_run(mode, swap);
        wait_done(cycles);
        check_cycles("done latency", cycles, n * (k + 3) + 1);
        idle(4);
        check_cycles("done pulses", done_pulses - pulses_before, 1);
        if (swap)
            verify_buffer(epu_pkg::REGION_INPUT, in_m, "in_buf");
        else
            verify_buffer(epu_pkg::REGION_OUTPUT, out_m, "out_buf");
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] bias;
        int          n;
        int          k;
        int          cycles;
        int          pulses_before;

        rng_state  = 32'd37;
        value_errs = 0;
        other_errs = 0;
        wb_req     = '0;
        rst        = 1'b0;
        for (int i = 0; i < 16; i++)
            @(posedge clk);
        #1;
        rst = 1'b1;

        read_csr(epu_pkg::CSR_STATUS, rd);
        check_status(rd, 1'b0, 1'b0);

        // Fill every word of every buffer, then read all back
        for (int i = 0; i < DEPTH; i++) begin
            in_m[i]  = next_rand();
            wt_m[i]  = next_rand();
            out_m[i] = next_rand();
            wb_write(buf_addr(epu_pkg::REGION_INPUT, i), in_m[i]);
            wb_write(buf_addr(epu_pkg::REGION_WEIGHT, i), wt_m[i]);
            wb_write(buf_addr(epu_pkg::REGION_OUTPUT, i), out_m[i]);
        end
        verify_buffer(epu_pkg::REGION_INPUT, in_m, "in_buf");
        verify_buffer(epu_pkg::REGION_WEIGHT, wt_m, "wt_buf");
        verify_buffer(epu_pkg::REGION_OUTPUT, out_m, "out_buf");

        // Register fields, ctrl with mode and swap one at a time and no start
        bias = next_rand();
        configure(bias, 21, 5);
        write_csr(epu_pkg::CSR_CTRL, 32'h2);
        read_csr(epu_pkg::CSR_BIAS, rd);
        check_word("csr_bias", rd, bias);
        read_csr(epu_pkg::CSR_OUT_LEN, rd);
        check_word("csr_out_len", rd, 32'd21);
        read_csr(epu_pkg::CSR_KER_LEN, rd);
        check_word("csr_ker_len", rd, 32'd5);
        read_csr(epu_pkg::CSR_CTRL, rd);
        check_word("csr_ctrl", rd, 32'h2);
        write_csr(epu_pkg::CSR_CTRL, 32'h4);
        read_csr(epu_pkg::CSR_CTRL, rd);
        check_word("csr_ctrl", rd, 32'h4);

        // Plain convolution over full-range data
        k = 1 + rand_below(8);
        n = 1 + rand_below(MAX_SPAN - k);
        do_run(epu_pkg::MODE_CONV, 1'b0, next_rand(), n, k);

        // Small positive data, negative weights, ReLU
        for (int i = 0; i < DEPTH; i++) begin
            in_m[i] = 32'(rand_below(256));
            wt_m[i] = 32'd0 - 32'(1 + rand_below(64));
            wb_write(buf_addr(epu_pkg::REGION_INPUT, i), in_m[i]);
            wb_write(buf_addr(epu_pkg::REGION_WEIGHT, i), wt_m[i]);
        end
        k = 2 + rand_below(7);
        n = 1 + rand_below(MAX_SPAN - k);
        do_run(epu_pkg::MODE_CONV_RELU, 1'b0, 32'(rand_below(40000)), n, k);

        // Chained layer from the output buffer into the input buffer
        k = 1 + rand_below(4);
        n = 1 + rand_below(MAX_SPAN - k);
        do_run(epu_pkg::MODE_CONV, 1'b1, next_rand(), n, k);
        read_csr(epu_pkg::CSR_STATUS, rd);
        check_status(rd, 1'b0, 1'b1);

        // A start while busy must not disturb the run
        k = 4 + rand_below(8);
        n = 8 + rand_below(24);
        bias = next_rand();
        configure(bias, n, k);
        model_conv(epu_pkg::MODE_CONV, 1'b0, bias, n, k);
        pulses_before = done_pulses;
        start_run(epu_pkg::MODE_CONV, 1'b0);
        read_csr(epu_pkg::CSR_STATUS, rd);
        check_status(rd, 1'b1, 1'b0);
        start_run(epu_pkg::MODE_CONV_RELU, 1'b1);
        wait_done(cycles);
        // The status read and the second start take two cycles each
        check_cycles("done latency", cycles + 4, n * (k + 3) + 1);
        idle(n * (k + 3) + 8);
        check_cycles("done pulses", done_pulses - pulses_before, 1);
        verify_buffer(epu_pkg::REGION_OUTPUT, out_m, "out_buf");
        verify_buffer(epu_pkg::REGION_INPUT, in_m, "in_buf");

        $display("Value errors: %0d, other failures: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: epu_top.sv
`default_nettype none

module epu_top #(
    parameter int BUF_DEPTH = 64
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire epu_pkg::wb_req_t wb_i,
    output epu_pkg::wb_rsp_t      wb_o,
    output logic                  done_o
);

    // Bus side of each buffer
    epu_pkg::buf_req_t in_bus_req;
    epu_pkg::buf_req_t wt_bus_req;
    epu_pkg::buf_req_t out_bus_req;
    logic [31:0]       in_bus_rdata;
    logic [31:0]       wt_bus_rdata;
    logic [31:0]       out_bus_rdata;

    // Engine side of each buffer
    epu_pkg::buf_req_t in_eng_req;
    epu_pkg::buf_req_t wt_eng_req;
    epu_pkg::buf_req_t out_eng_req;
    logic [31:0]       in_eng_rdata;
    logic [31:0]       wt_eng_rdata;
    logic [31:0]       out_eng_rdata;

    epu_pkg::epu_cfg_t cfg;
    logic              start;
    logic              busy;

    epu_bus_slave u_slave (
        .clk         (clk),
        .rst         (rst),
        .wb_i        (wb_i),
        .wb_o        (wb_o),
        .in_req_o    (in_bus_req),
        .wt_req_o    (wt_bus_req),
        .out_req_o   (out_bus_req),
        .in_rdata_i  (in_bus_rdata),
        .wt_rdata_i  (wt_bus_rdata),
        .out_rdata_i (out_bus_rdata),
        .cfg_o       (cfg),
        .start_o     (start),
        .busy_i      (busy),
        .done_i      (done_o)
    );

    epu_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_in_buf (
        .clk (clk), .bus_req_i (in_bus_req), .bus_rdata_o (in_bus_rdata),
        .eng_req_i (in_eng_req), .eng_rdata_o (in_eng_rdata)
    );

    epu_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_wt_buf (
        .clk (clk), .bus_req_i (wt_bus_req), .bus_rdata_o (wt_bus_rdata),
        .eng_req_i (wt_eng_req), .eng_rdata_o (wt_eng_rdata)
    );

    epu_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_out_buf (
        .clk (clk), .bus_req_i (out_bus_req), .bus_rdata_o (out_bus_rdata),
        .eng_req_i (out_eng_req), .eng_rdata_o (out_eng_rdata)
    );

    epu_conv_engine #(.BUF_DEPTH(BUF_DEPTH)) u_engine (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .cfg_i       (cfg),
        .busy_o      (busy),
        .done_o      (done_o),
        .in_req_o    (in_eng_req),
        .wt_req_o    (wt_eng_req),
        .out_req_o   (out_eng_req),
        .in_rdata_i  (in_eng_rdata),
        .wt_rdata_i  (wt_eng_rdata),
        .out_rdata_i (out_eng_rdata)
    );

endmodule

`default_nettype wire

// File: list.f
epu_pkg.sv
epu_bus_slave.sv
epu_buffer.sv
epu_conv_engine.sv
epu_top.sv
tb_clock_gen.sv
epu_assert.sv
epu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the EPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module epu_tb -f list.f \
    --Mdir obj_dir -o epu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/epu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F '** FAIL **' "$LOG"; then
    exit 1
fi
if ! grep -q -F '** PASS **' "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire
